/* common/spi_ctrl_pkg.sv */
// spi controller package: byte and counter widths, synchronizer depth, command codes
package spi_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // one spi byte, received msb first
  localparam int unsigned byte_w = 8;

  // bit counter inside a byte, wraps after byte_w bits
  localparam int unsigned bit_cnt_w = 3;

  // timestamp counter, also the word shifted out on miso
  localparam int unsigned stamp_w = 32;

  ////////////////////////////////////////////////////////////
  // synchronizer
  ////////////////////////////////////////////////////////////

  // flops per spi pad
  // edges are found on the two oldest stages
  localparam int unsigned sync_depth = 3;

  ////////////////////////////////////////////////////////////
  // command bytes
  ////////////////////////////////////////////////////////////

  // timestamp counter back to zero
  localparam logic [byte_w-1:0] cmd_clear_stamp = 8'hcc;

  // status led on
  localparam logic [byte_w-1:0] cmd_led_on = 8'hcd;

  // status led off
  localparam logic [byte_w-1:0] cmd_led_off = 8'hce;

  // any other byte value is ignored by the executor

endpackage

/* rtl/cmd_exec.sv */
// command executor: decodes received bytes, runs the timestamp counter and the status led
`timescale 1ns/1ps

module cmd_exec
  import spi_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               byte_valid,
  input  logic [byte_w-1:0]  byte_data,
  output logic [stamp_w-1:0] stamp,
  output logic               status_led
);

  // decoded command strobes, only one can be high
  logic do_clear;
  logic do_led_on;
  logic do_led_off;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  // byte_valid is a one-cycle pulse, no handshake
  assign do_clear   = byte_valid && (byte_data == cmd_clear_stamp);
  assign do_led_on  = byte_valid && (byte_data == cmd_led_on);
  assign do_led_off = byte_valid && (byte_data == cmd_led_off);

  ////////////////////////////////////////////////////////////
  // timestamp counter
  ////////////////////////////////////////////////////////////

  // free running, wraps at 2^32
  // a clear shows as zero the cycle after byte_valid
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      stamp <= '0;
    end
    else if (do_clear)
    begin
      stamp <= '0;
    end
    else
    begin
      stamp <= stamp + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // status led
  ////////////////////////////////////////////////////////////

  // set and clear are separate bytes
  // anything else leaves the led as it is
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      status_led <= 1'b0;
    end
    else if (do_led_on)
    begin
      status_led <= 1'b1;
    end
    else if (do_led_off)
    begin
      status_led <= 1'b0;
    end
  end

endmodule

/* rtl/heartbeat_blinker.sv */
// heartbeat blinker: free-running divider, one selected bit drives the heartbeat led
`timescale 1ns/1ps

module heartbeat_blinker #(
  // divider bit on the led, period is 2^(blink_shift+1) cycles
  parameter int blink_shift = 23
) (
  input  logic clk,
  input  logic rst_n,
  output logic heartbeat_led
);

  // same width as the timestamp, blink_shift must stay below it
  logic [31:0] div_q;

  // counts every cycle, no enable
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_q <= '0;
    else
      div_q <= div_q + 1'b1;
  end

  // each level lasts 2^blink_shift cycles
  assign heartbeat_led = div_q[blink_shift];

endmodule

/* rtl/spi_ctrl_top.sv */
// spi controller top: front end, command executor, transmit shifter and heartbeat
`timescale 1ns/1ps

module spi_ctrl_top
  import spi_ctrl_pkg::*;
#(
  // handed to the heartbeat divider
  parameter int blink_shift = 23
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic mosi,
  input  logic cs_n,
  output logic miso,
  output logic status_led,
  output logic heartbeat_led
);

  // front end pulses and levels
  logic sck_rise;
  logic sck_fall;
  logic frame_start;
  logic frame_active;
  logic mosi_bit;

  // received byte toward the executor
  logic              byte_valid;
  logic [byte_w-1:0] byte_data;

  // live counter toward the transmit side
  logic [stamp_w-1:0] stamp;

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  spi_sync spi_sync_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sck          (sck),
    .mosi         (mosi),
    .cs_n         (cs_n),
    .sck_rise     (sck_rise),
    .sck_fall     (sck_fall),
    .frame_start  (frame_start),
    .frame_active (frame_active),
    .mosi_bit     (mosi_bit)
  );

  spi_rx_shift spi_rx_shift_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sck_rise     (sck_rise),
    .frame_active (frame_active),
    .mosi_bit     (mosi_bit),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data)
  );

  ////////////////////////////////////////////////////////////
  // commands, output side
  ////////////////////////////////////////////////////////////

  cmd_exec cmd_exec_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .stamp      (stamp),
    .status_led (status_led)
  );

  // cs_n fall to miso valid is four clk cycles
  spi_tx_shift spi_tx_shift_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_start  (frame_start),
    .frame_active (frame_active),
    .sck_fall     (sck_fall),
    .stamp        (stamp),
    .miso         (miso)
  );

  heartbeat_blinker #(
    .blink_shift (blink_shift)
  ) heartbeat_blinker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .heartbeat_led (heartbeat_led)
  );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

# build the testbench with the rtl from the file list
verilator --binary --assert -Wno-fatal -j 0 --top-module spi_ctrl_tb -f sources.f

# run, show the output, decide on the pass line
out=$(./obj_dir/Vspi_ctrl_tb)
echo "$out"
if echo "$out" | grep -qx '>>> PASS'; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sources.f */
common/spi_ctrl_pkg.sv
spi_frontend/spi_sync.sv
spi_frontend/spi_rx_shift.sv
spi_frontend/spi_tx_shift.sv
rtl/cmd_exec.sv
rtl/heartbeat_blinker.sv
rtl/spi_ctrl_top.sv
verif/spi_ctrl_tb.sv

/* spi_frontend/spi_rx_shift.sv */
// spi receive shifter: counts bits and assembles msb-first bytes, pulses byte_valid
`timescale 1ns/1ps

module spi_rx_shift
  import spi_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sck_rise,
  input  logic              frame_active,
  input  logic              mosi_bit,
  output logic              byte_valid,
  output logic [byte_w-1:0] byte_data
);

  // position inside the current byte
  logic [bit_cnt_w-1:0] bit_cnt;

  // received bits, newest at bit 0
  logic [byte_w-1:0] shift_q;

  // last bit of a byte arrives on this sck rise
  logic last_bit;

  assign last_bit = frame_active && sck_rise && (bit_cnt == {bit_cnt_w{1'b1}});

  ////////////////////////////////////////////////////////////
  // bit counter
  ////////////////////////////////////////////////////////////

  // held at zero outside a frame
  // so a byte cut short by deselect is thrown away
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (!frame_active)
      bit_cnt <= '0;
    else if (sck_rise)
      bit_cnt <= bit_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // data shift register
  ////////////////////////////////////////////////////////////

  // shift left, msb comes in first
  always_ff @(posedge clk)
  begin
    if (frame_active && sck_rise)
      shift_q <= {shift_q[byte_w-2:0], mosi_bit};
  end

  // one cycle after the eighth rise
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      byte_valid <= 1'b0;
    else
      byte_valid <= last_bit;
  end

  // holds until the next sck rise shifts again
  assign byte_data = shift_q;

endmodule

/* spi_frontend/spi_sync.sv */
// spi pad synchronizer: brings sck, mosi and cs_n into clk, makes edge and frame pulses
`timescale 1ns/1ps

module spi_sync
  import spi_ctrl_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic mosi,
  input  logic cs_n,
  output logic sck_rise,
  output logic sck_fall,
  output logic frame_start,
  output logic frame_active,
  output logic mosi_bit
);

  // shift registers, bit 0 is the newest sample
  logic [sync_depth-1:0] sck_q;
  logic [sync_depth-1:0] mosi_q;
  logic [sync_depth-1:0] cs_q;

  ////////////////////////////////////////////////////////////
  // pad sampling
  ////////////////////////////////////////////////////////////

  // cs stages come up high so reset itself looks like no frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_q  <= '0;
      mosi_q <= '0;
      cs_q   <= '1;
    end
    else
    begin
      sck_q  <= {sck_q[sync_depth-2:0], sck};
      mosi_q <= {mosi_q[sync_depth-2:0], mosi};
      cs_q   <= {cs_q[sync_depth-2:0], cs_n};
    end
  end

  ////////////////////////////////////////////////////////////
  // edge pulses, one clk wide
  ////////////////////////////////////////////////////////////

  // compare the two oldest stages, then register the result
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_rise    <= 1'b0;
      sck_fall    <= 1'b0;
      frame_start <= 1'b0;
    end
    else
    begin
      sck_rise    <= (sck_q[2:1] == 2'b01);
      sck_fall    <= (sck_q[2:1] == 2'b10);
      // cs_n falling opens a frame
      frame_start <= (cs_q[2:1] == 2'b10);
    end
  end

  // level outputs straight off the middle stage
  assign frame_active = ~cs_q[1];
  assign mosi_bit     = mosi_q[1];

endmodule

/* spi_frontend/spi_tx_shift.sv */
// spi transmit shifter: captures the timestamp at frame start and shifts it onto miso
`timescale 1ns/1ps

module spi_tx_shift
  import spi_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               frame_start,
  input  logic               frame_active,
  input  logic               sck_fall,
  input  logic [stamp_w-1:0] stamp,
  output logic               miso
);

  // outgoing word, msb on the wire
  logic [stamp_w-1:0] tx_q;

  ////////////////////////////////////////////////////////////
  // load and shift
  ////////////////////////////////////////////////////////////

  // frame_start comes one cycle after frame_active rises,
  // so the load always lands inside the frame
  // mode 0: the master samples on rise, we move on fall
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_q <= '0;
    end
    else if (frame_start)
    begin
      // live counter value at this edge
      tx_q <= stamp;
    end
    else if (frame_active && sck_fall)
    begin
      // zero fill, bits past 32 read as low
      tx_q <= {tx_q[stamp_w-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////
  // pad
  ////////////////////////////////////////////////////////////

  // single slave on the bus, miso is never released
  // low after reset, captured msb from the cycle after frame_start
  assign miso = tx_q[stamp_w-1];

endmodule

/* verif/spi_ctrl_tb.sv */
// spi controller testbench: mode-0 spi master, reference timestamp model, assertion checks
`timescale 1ns/1ps

module spi_ctrl_tb
  import spi_ctrl_pkg::*;
();

  localparam int half_period = 50;
  // clk cycles per sck level
  localparam int sck_hold = 8;
  // eighth sck rise to command effect
  localparam int cmd_latency = 5;
  // cs_n fall to timestamp capture
  localparam int capture_lag = 3;
  localparam int hb_shift = 4;
  localparam int hb_level = 16;
  localparam int hb_timeout = 64;

  logic clk = 1'b0;
  logic rst_n;
  logic sck;
  logic mosi;
  logic cs_n;
  logic miso;
  logic status_led;
  logic heartbeat_led;

  // edge count, after edge n it reads n
  int cyc = 0;
  int err_cnt = 0;
  int check_cnt = 0;
  int seed = 50;
  // reference model: stamp is cyc minus the last restart point
  int stamp_base = 0;
  int rise_cyc = 0;

  spi_ctrl_top #(
    .blink_shift (hb_shift)
  ) spi_ctrl_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .sck           (sck),
    .mosi          (mosi),
    .cs_n          (cs_n),
    .miso          (miso),
    .status_led    (status_led),
    .heartbeat_led (heartbeat_led)
  );

  always #half_period clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // all driving and sampling happens 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    int i;
    for (i = 0; i < n; i++)
      next_cycle();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    assert (actual === expected)
    else
    begin
      err_cnt++;
      $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // filler bytes stay below the command codes
  task automatic random_filler(output logic [byte_w-1:0] fill);
    int r;
    r = $random(seed);
    fill = r[byte_w-1:0];
    if (fill >= cmd_clear_stamp)
      fill = fill - 8'h40;
  endtask

  ////////////////////////////////////////////////////////////
  // spi master, mode 0
  ////////////////////////////////////////////////////////////

  // one bit: mosi set while sck low, miso read just before the rise
  task automatic spi_bit(input logic mosi_val, output logic miso_val);
    mosi = mosi_val;
    wait_cycles(sck_hold);
    miso_val = miso;
    sck = 1'b1;
    rise_cyc = cyc;
    wait_cycles(sck_hold);
    sck = 1'b0;
  endtask

  task automatic send_byte(input logic [byte_w-1:0] data);
    logic unused_miso;
    int i;
    for (i = byte_w - 1; i >= 0; i--)
      spi_bit(data[i], unused_miso);
    // counter restarts a fixed latency after the eighth rise
    if (data == cmd_clear_stamp)
      stamp_base = rise_cyc + cmd_latency;
  endtask

  // deselect after the last fall, then an idle gap
  task automatic frame_close();
    wait_cycles(sck_hold);
    cs_n = 1'b1;
    mosi = 1'b0;
    wait_cycles(2 * sck_hold);
  endtask

  task automatic send_frame(input logic [byte_w-1:0] data);
    cs_n = 1'b0;
    send_byte(data);
    frame_close();
  endtask

  // 32 bits msb first, mosi held low so only 0x00 bytes go in
  task automatic read_stamp(output logic [stamp_w-1:0] word, output int fall_cyc);
    logic bit_in;
    int i;
    cs_n = 1'b0;
    fall_cyc = cyc;
    word = '0;
    for (i = 0; i < stamp_w; i++)
    begin
      spi_bit(1'b0, bit_in);
      word = {word[stamp_w-2:0], bit_in};
    end
    frame_close();
  endtask

  // cycles until heartbeat_led changes, bounded by hb_timeout
  task automatic measure_level(output int len);
    logic level;
    level = heartbeat_led;
    len = 0;
    while (heartbeat_led == level && len <= hb_timeout)
    begin
      next_cycle();
      len++;
    end
    check_cnt++;
    assert (heartbeat_led != level)
    else
    begin
      err_cnt++;
      $display("heartbeat_led stuck at %b for %0d cycles", level, len);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [byte_w-1:0] fill;
    logic [stamp_w-1:0] word_a;
    logic [stamp_w-1:0] word_b;
    logic led_expected;
    logic unused_miso;
    int fall_a;
    int fall_b;
    int len;
    int i;
    rst_n = 1'b0;
    sck = 1'b0;
    mosi = 1'b0;
    cs_n = 1'b1;
    wait_cycles(3);
    rst_n = 1'b1;
    stamp_base = cyc;
    check_value("reset status_led", 0, 32'(status_led));
    check_value("reset heartbeat_led", 0, 32'(heartbeat_led));
    check_value("reset miso", 0, 32'(miso));

    // first level is partial, the rest last 2^hb_shift cycles
    measure_level(len);
    for (i = 0; i < 3; i++)
    begin
      measure_level(len);
      check_value("heartbeat level length", hb_level, len);
    end

    // led commands as the only byte of a frame
    send_frame(cmd_led_on);
    check_value("led on single byte", 1, 32'(status_led));
    send_frame(cmd_led_off);
    check_value("led off single byte", 0, 32'(status_led));

    // filler then command in one frame
    random_filler(fill);
    cs_n = 1'b0;
    send_byte(fill);
    check_value("led after filler", 0, 32'(status_led));
    send_byte(cmd_led_on);
    frame_close();
    check_value("led on second byte", 1, 32'(status_led));
    random_filler(fill);
    cs_n = 1'b0;
    send_byte(fill);
    check_value("led after filler", 1, 32'(status_led));
    send_byte(cmd_led_off);
    frame_close();
    check_value("led off second byte", 0, 32'(status_led));

    // lone random bytes in both led states
    led_expected = 1'b0;
    for (i = 0; i < 4; i++)
    begin
      if (i == 2)
      begin
        send_frame(cmd_led_on);
        led_expected = 1'b1;
      end
      random_filler(fill);
      send_frame(fill);
      check_value("led after random byte", 32'(led_expected), 32'(status_led));
    end
    send_frame(cmd_led_off);

    // four bits of a led-on byte, then deselect
    cs_n = 1'b0;
    for (i = byte_w - 1; i >= 4; i--)
      spi_bit(cmd_led_on[i], unused_miso);
    frame_close();
    check_value("led after partial byte", 0, 32'(status_led));
    send_frame(cmd_led_on);
    check_value("led after full byte", 1, 32'(status_led));

    // clear, a random gap, then read back
    send_frame(cmd_clear_stamp);
    random_filler(fill);
    wait_cycles(10 + int'(fill[5:0]));
    read_stamp(word_a, fall_a);
    check_value("stamp after clear", fall_a + capture_lag - stamp_base, word_a);

    // second read with no clear in between
    wait_cycles(37);
    read_stamp(word_b, fall_b);
    check_value("stamp second read", fall_b + capture_lag - stamp_base, word_b);
    check_value("stamp difference", fall_b - fall_a, word_b - word_a);

    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
